// ==== decode_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I plus the custom-0 warp controls. Integer registers only, no float file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define DEC_XLEN         32
`define DEC_NUM_WARPS    4
`define DEC_NUM_THREADS  4
`define DEC_REG_BITS     5
`define DEC_IMM_BITS     20

`define DEC_OP_I         7'b0010011
`define DEC_OP_R         7'b0110011
`define DEC_OP_LUI       7'b0110111
`define DEC_OP_AUIPC     7'b0010111
`define DEC_OP_JAL       7'b1101111
`define DEC_OP_JALR      7'b1100111
`define DEC_OP_B         7'b1100011
`define DEC_OP_L         7'b0000011
`define DEC_OP_S         7'b0100011
`define DEC_OP_FENCE     7'b0001111
`define DEC_OP_SYS       7'b1110011
`define DEC_OP_EXT1      7'b0001011 // custom-0, warp controls

`define DEC_CSR_FFLAGS   12'h001
`define DEC_CSR_FRM      12'h002
`define DEC_CSR_FCSR     12'h003

`endif

// ==== decode_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded record layout. Unused fields are zero, rs3 is never used
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

    typedef logic [`DEC_XLEN-1:0]                instr_t;
    typedef logic [`DEC_XLEN-1:0]                pc_t;
    typedef logic [$clog2(`DEC_NUM_WARPS)-1:0]   wid_t;
    typedef logic [`DEC_NUM_THREADS-1:0]         tmask_t;
    typedef logic [`DEC_REG_BITS-1:0]            reg_idx_t;
    typedef logic [`DEC_IMM_BITS-1:0]            imm_t;
    typedef logic [3:0]                          op_type_t;
    typedef logic [1:0]                          xregs_t;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef enum logic [1:0] {
        ALU_ARITH  = 2'd0,
        ALU_BRANCH = 2'd1
    } alu_xtype_e;

    // ALU arithmetic
    localparam op_type_t OP_ALU_ADD   = 4'd0;
    localparam op_type_t OP_ALU_SUB   = 4'd1;
    localparam op_type_t OP_ALU_SLL   = 4'd2;
    localparam op_type_t OP_ALU_SLT   = 4'd3;
    localparam op_type_t OP_ALU_SLTU  = 4'd4;
    localparam op_type_t OP_ALU_XOR   = 4'd5;
    localparam op_type_t OP_ALU_SRL   = 4'd6;
    localparam op_type_t OP_ALU_SRA   = 4'd7;
    localparam op_type_t OP_ALU_OR    = 4'd8;
    localparam op_type_t OP_ALU_AND   = 4'd9;
    localparam op_type_t OP_ALU_LUI   = 4'd10;
    localparam op_type_t OP_ALU_AUIPC = 4'd11;

    // ALU branch xtype
    localparam op_type_t OP_BR_BEQ    = 4'd0;
    localparam op_type_t OP_BR_BNE    = 4'd1;
    localparam op_type_t OP_BR_BLT    = 4'd2;
    localparam op_type_t OP_BR_BGE    = 4'd3;
    localparam op_type_t OP_BR_BLTU   = 4'd4;
    localparam op_type_t OP_BR_BGEU   = 4'd5;
    localparam op_type_t OP_BR_JAL    = 4'd6;
    localparam op_type_t OP_BR_JALR   = 4'd7;
    localparam op_type_t OP_BR_ECALL  = 4'd8;
    localparam op_type_t OP_BR_EBREAK = 4'd9;
    localparam op_type_t OP_BR_URET   = 4'd10;
    localparam op_type_t OP_BR_SRET   = 4'd11;
    localparam op_type_t OP_BR_MRET   = 4'd12;

    localparam op_type_t OP_LSU_FENCE = 4'd15; // Loads/stores use {is_store, funct3}

    localparam op_type_t OP_SFU_CSRRW   = 4'd0;
    localparam op_type_t OP_SFU_CSRRS   = 4'd1;
    localparam op_type_t OP_SFU_CSRRC   = 4'd2;
    localparam op_type_t OP_SFU_TMC     = 4'd8;
    localparam op_type_t OP_SFU_WSPAWN  = 4'd9;
    localparam op_type_t OP_SFU_SPLIT   = 4'd10;
    localparam op_type_t OP_SFU_JOIN    = 4'd11;
    localparam op_type_t OP_SFU_BARRIER = 4'd12;
    localparam op_type_t OP_SFU_PRED    = 4'd13;

    localparam int XREG_FFLAGS = 0;
    localparam int XREG_FRM    = 1;

    typedef struct packed {
        imm_t       imm;      // Offset for LSU, CSR address for SFU
        logic       use_pc;
        logic       use_imm;
        alu_xtype_e xtype;
        logic       is_store;
        logic       is_neg;
        logic       csr_imm;
    } op_args_t;

    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
        instr_t instr;
    } fetch_req_t;

    typedef struct packed {
        wid_t       wid;
        tmask_t     tmask;
        pc_t        pc;
        ex_type_e   ex_type;
        op_type_t   op_type;
        op_args_t   op_args;
        logic       wb;
        xregs_t     rd_xregs;
        xregs_t     wr_xregs;
        logic [2:0] used_rs; // {rs3, rs2, rs1}
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rs3;
    } decode_rsp_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic unlock;
    } sched_note_t;

endpackage

`default_nettype wire

// ==== imm_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// B offset is the raw 12-bit field (halfword units), not shifted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "decode_settings.svh"

module imm_gen import decode_pkg::*; (
    input  instr_t instr,
    output imm_t   imm
);

    localparam int EXT = `DEC_IMM_BITS - 12;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [11:0] b_imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // Shifts carry only shamt
    assign i_imm  = (funct3[1:0] == 2'b01) ? {7'b0, instr[24:20]} : instr[31:20];
    assign s_imm  = {instr[31:25], instr[11:7]};
    assign b_imm  = {instr[31], instr[7], instr[30:25], instr[11:8]};

    always_comb begin
        case (opcode)
            `DEC_OP_I:                  imm = {{EXT{i_imm[11]}}, i_imm};
            `DEC_OP_JALR, `DEC_OP_L:    imm = {{EXT{instr[31]}}, instr[31:20]};
            `DEC_OP_S:                  imm = {{EXT{s_imm[11]}}, s_imm};
            `DEC_OP_B:                  imm = {{EXT{b_imm[11]}}, b_imm};
            `DEC_OP_JAL:                imm = {instr[31], instr[19:12], instr[20], instr[30:21]};
            `DEC_OP_LUI, `DEC_OP_AUIPC: imm = instr[31:12];
            `DEC_OP_SYS: begin
                if (funct3[1:0] != 2'b00)
                    imm = {{EXT{1'b0}}, instr[31:20]}; // CSR address
                else
                    imm = imm_t'(4); // Return address step
            end
            default:                    imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== op_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reserved funct encodings fall back to a legal op, never X
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "decode_settings.svh"

module op_decoder import decode_pkg::*; (
    input  instr_t   instr,
    input  imm_t     imm,
    output ex_type_e ex_type,
    output op_type_t op_type,
    output op_args_t op_args,
    output logic     use_rd,
    output logic     use_rs1,
    output logic     use_rs2,
    output logic     wstall
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_type_t   alu_op;
    op_type_t   br_op;
    op_type_t   sys_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        case (funct3)
            3'h0: alu_op = (opcode[5] && funct7[5]) ? OP_ALU_SUB : OP_ALU_ADD; // R-type only
            3'h1: alu_op = OP_ALU_SLL;
            3'h2: alu_op = OP_ALU_SLT;
            3'h3: alu_op = OP_ALU_SLTU;
            3'h4: alu_op = OP_ALU_XOR;
            3'h5: alu_op = funct7[5] ? OP_ALU_SRA : OP_ALU_SRL;
            3'h6: alu_op = OP_ALU_OR;
            3'h7: alu_op = OP_ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1:    br_op = OP_BR_BNE;
            3'h4:    br_op = OP_BR_BLT;
            3'h5:    br_op = OP_BR_BGE;
            3'h6:    br_op = OP_BR_BLTU;
            3'h7:    br_op = OP_BR_BGEU;
            default: br_op = OP_BR_BEQ;
        endcase
    end

    always_comb begin
        case (instr[31:20])
            12'h001: sys_op = OP_BR_EBREAK;
            12'h002: sys_op = OP_BR_URET;
            12'h102: sys_op = OP_BR_SRET;
            12'h302: sys_op = OP_BR_MRET;
            default: sys_op = OP_BR_ECALL;
        endcase
    end

    always_comb begin
        ex_type     = EX_ALU;
        op_type     = '0;
        op_args     = '0;
        op_args.imm = imm; // Zero for formats without one
        use_rd      = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        wstall      = 1'b0;
        case (opcode)
            `DEC_OP_I, `DEC_OP_R: begin
                op_type         = alu_op;
                op_args.use_imm = ~opcode[5];
                use_rd          = 1'b1;
                use_rs1         = 1'b1;
                use_rs2         = opcode[5];
            end
            `DEC_OP_LUI, `DEC_OP_AUIPC: begin
                op_type         = opcode[5] ? OP_ALU_LUI : OP_ALU_AUIPC;
                op_args.use_pc  = ~opcode[5];
                op_args.use_imm = 1'b1;
                use_rd          = 1'b1;
            end
            `DEC_OP_JAL, `DEC_OP_JALR, `DEC_OP_B: begin
                op_args.xtype   = ALU_BRANCH;
                op_args.use_pc  = (opcode != `DEC_OP_JALR);
                op_args.use_imm = 1'b1;
                wstall          = 1'b1;
                use_rd          = (opcode != `DEC_OP_B);
                use_rs1         = (opcode != `DEC_OP_JAL);
                use_rs2         = (opcode == `DEC_OP_B);
                if (opcode == `DEC_OP_JAL)
                    op_type = OP_BR_JAL;
                else if (opcode == `DEC_OP_JALR)
                    op_type = OP_BR_JALR;
                else
                    op_type = br_op;
            end
            `DEC_OP_FENCE: begin
                ex_type = EX_LSU;
                op_type = OP_LSU_FENCE;
            end
            `DEC_OP_L, `DEC_OP_S: begin
                ex_type          = EX_LSU;
                op_type          = {opcode[5], funct3};
                op_args.is_store = opcode[5];
                use_rd           = ~opcode[5];
                use_rs1          = 1'b1;
                use_rs2          = opcode[5];
            end
            `DEC_OP_SYS: begin
                use_rd = 1'b1;
                if (funct3[1:0] != 2'b00) begin
                    ex_type         = EX_SFU;
                    op_args.csr_imm = funct3[2];
                    use_rs1         = ~funct3[2]; // rs1 field is zimm
                    case (funct3[1:0])
                        2'd1:    op_type = OP_SFU_CSRRW;
                        2'd2:    op_type = OP_SFU_CSRRS;
                        default: op_type = OP_SFU_CSRRC;
                    endcase
                end else begin
                    op_type         = sys_op;
                    op_args.xtype   = ALU_BRANCH;
                    op_args.use_pc  = 1'b1;
                    op_args.use_imm = 1'b1;
                    wstall          = 1'b1;
                end
            end
            `DEC_OP_EXT1: begin
                if (funct7 == 7'h00 && funct3 <= 3'h5) begin
                    ex_type = EX_SFU;
                    wstall  = 1'b1;
                    use_rs1 = 1'b1;
                    case (funct3)
                        3'h0: op_type = OP_SFU_TMC;
                        3'h1: begin
                            op_type = OP_SFU_WSPAWN;
                            use_rs2 = 1'b1;
                        end
                        3'h2: begin
                            op_type        = OP_SFU_SPLIT;
                            op_args.is_neg = instr[20]; // rs2[0]
                            use_rd         = 1'b1;
                        end
                        3'h3: op_type = OP_SFU_JOIN;
                        3'h4: begin
                            op_type = OP_SFU_BARRIER;
                            use_rs2 = 1'b1;
                        end
                        default: begin // PRED
                            op_type        = OP_SFU_PRED;
                            op_args.is_neg = instr[7]; // rd[0]
                            use_rs2        = 1'b1;
                        end
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== csr_dep.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tracks FFLAGS/FRM only; other CSRs give no dependency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "decode_settings.svh"

module csr_dep import decode_pkg::*; (
    input  instr_t instr,
    output xregs_t rd_xregs,
    output xregs_t wr_xregs
);

    logic [11:0] addr;
    logic [2:0]  funct3;
    logic        is_csr;
    logic        hit_fflags;
    logic        hit_frm;
    logic        csr_write;

    assign addr       = instr[31:20];
    assign funct3     = instr[14:12];
    assign is_csr     = (instr[6:0] == `DEC_OP_SYS) && (funct3[1:0] != 2'b00);
    assign hit_fflags = (addr == `DEC_CSR_FFLAGS) || (addr == `DEC_CSR_FCSR);
    assign hit_frm    = (addr == `DEC_CSR_FRM) || (addr == `DEC_CSR_FCSR);
    // Set/clear with x0 or zimm 0 leaves the CSR alone
    assign csr_write  = (funct3[1:0] == 2'b01) || (instr[19:15] != 5'd0);

    always_comb begin
        rd_xregs              = '0;
        wr_xregs              = '0;
        rd_xregs[XREG_FFLAGS] = is_csr && hit_fflags;
        rd_xregs[XREG_FRM]    = is_csr && hit_frm;
        wr_xregs[XREG_FFLAGS] = is_csr && hit_fflags && csr_write;
        wr_xregs[XREG_FRM]    = is_csr && hit_frm && csr_write;
    end

endmodule

`default_nettype wire

// ==== decode_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One entry; in_ready depends combinationally on out_ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module decode_buffer import decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  decode_rsp_t in_data,
    output logic        out_valid,
    input  logic        out_ready,
    output decode_rsp_t out_data
);

    logic        full_q;
    decode_rsp_t data_q;

    // Take a new entry when empty or when the held one leaves this edge
    assign in_ready = ~full_q || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            full_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full_q;
    assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== warp_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One cycle decode latency; scheduler note in the fetch cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module warp_decode import decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  fetch_req_t  fetch_req,
    output logic        decode_valid,
    input  logic        decode_ready,
    output decode_rsp_t decode_rsp,
    output sched_note_t sched_note
);

    instr_t      instr;
    imm_t        imm;
    ex_type_e    ex_type;
    op_type_t    op_type;
    op_args_t    op_args;
    logic        use_rd;
    logic        use_rs1;
    logic        use_rs2;
    logic        wstall;
    xregs_t      rd_xregs;
    xregs_t      wr_xregs;
    decode_rsp_t dec_rec;
    logic        fetch_fire;

    assign instr = fetch_req.instr;

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    op_decoder u_op_decoder (
        .instr   (instr),
        .imm     (imm),
        .ex_type (ex_type),
        .op_type (op_type),
        .op_args (op_args),
        .use_rd  (use_rd),
        .use_rs1 (use_rs1),
        .use_rs2 (use_rs2),
        .wstall  (wstall)
    );

    csr_dep u_csr_dep (
        .instr    (instr),
        .rd_xregs (rd_xregs),
        .wr_xregs (wr_xregs)
    );

    always_comb begin
        dec_rec          = '0; // rs3 stays zero
        dec_rec.wid      = fetch_req.wid;
        dec_rec.tmask    = fetch_req.tmask;
        dec_rec.pc       = fetch_req.pc;
        dec_rec.ex_type  = ex_type;
        dec_rec.op_type  = op_type;
        dec_rec.op_args  = op_args;
        dec_rec.wb       = use_rd && (instr[11:7] != 5'd0); // No writes to x0
        dec_rec.rd_xregs = rd_xregs;
        dec_rec.wr_xregs = wr_xregs;
        dec_rec.used_rs  = {1'b0, use_rs2, use_rs1};
        dec_rec.rd       = use_rd ? instr[11:7] : '0;
        dec_rec.rs1      = use_rs1 ? instr[19:15] : '0;
        dec_rec.rs2      = use_rs2 ? instr[24:20] : '0;
    end

    decode_buffer u_decode_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec_rec),
        .out_valid (decode_valid),
        .out_ready (decode_ready),
        .out_data  (decode_rsp)
    );

    assign fetch_fire        = fetch_valid && fetch_ready;
    assign sched_note.valid  = fetch_fire;
    assign sched_note.wid    = fetch_req.wid;
    assign sched_note.unlock = ~wstall; // Control flow holds the warp

endmodule

`default_nettype wire

// ==== decode_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected entries are pushed in fetch order by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; (
    input wire logic        clk,
    input wire logic        arst_n,
    input wire logic        fetch_valid,
    input wire logic        fetch_ready,
    input wire logic        decode_valid,
    input wire logic        decode_ready,
    input wire decode_rsp_t decode_rsp,
    input wire sched_note_t sched_note
);

    string       fname_q[$];
    sched_note_t fnote_q[$];
    string       dname_q[$];
    decode_rsp_t drsp_q[$];
    int          fetch_count = 0;
    int          check_count = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    logic        fire_d      = 1'b0;
    string       nm;
    sched_note_t note;
    decode_rsp_t exp_rsp;
    int          held;

    task push_expected(input string name, input decode_rsp_t rsp, input logic unlock);
        fname_q.push_back(name);
        fnote_q.push_back({1'b1, rsp.wid, unlock});
        dname_q.push_back(name);
        drsp_q.push_back(rsp);
    endtask

    task print_counts();
        $display("Checked %0d records, %0d passed, %0d errors",
                 check_count, pass_count, fail_count);
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            fire_d <= 1'b0;
        end else begin
            held = fetch_count - check_count; // Records inside the one-entry buffer
            if (fetch_ready !== (held == 0 || decode_ready)) begin
                $display("fetch_ready was %b with %0d held record(s)", fetch_ready, held);
                fail_count++;
            end
            if (fetch_valid && fetch_ready) begin
                if (fname_q.size() == 0) begin
                    $display("Fetch transfer happened with no expected entry left");
                    fail_count++;
                end else begin
                    nm   = fname_q.pop_front();
                    note = fnote_q.pop_front();
                    if (sched_note !== note) begin
                        $display("[ERROR] %s note: expected %h, actual %h", nm, note, sched_note);
                        fail_count++;
                    end
                end
                fetch_count++;
            end else if (sched_note.valid) begin
                $display("Scheduler note was valid without a fetch transfer");
                fail_count++;
            end
            if (fire_d && !decode_valid) begin // One cycle latency
                $display("Decoded record did not appear one cycle after its fetch");
                fail_count++;
            end
            if (decode_valid && decode_ready) begin
                if (dname_q.size() == 0) begin
                    $display("Decoded record arrived with no expected entry left");
                    fail_count++;
                end else begin
                    nm      = dname_q.pop_front();
                    exp_rsp = drsp_q.pop_front();
                    if (decode_rsp !== exp_rsp) begin
                        $display("[ERROR] %s: expected %h, actual %h", nm, exp_rsp, decode_rsp);
                        fail_count++;
                    end else begin
                        $display("PASS  %s", nm);
                        pass_count++;
                    end
                end
                check_count++;
            end
            fire_d <= fetch_valid && fetch_ready;
        end
    end

endmodule

`default_nettype wire

// ==== tb_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table driven; gaps and stalls come from a fixed-seed LCG
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

`include "decode_settings.svh"

module tb_decode import decode_pkg::*; ();

    localparam int TIMEOUT = 200;
    localparam logic [5:0] F_PC = 6'b100000;  // {use_pc, use_imm, branch, store, neg, csr_imm}
    localparam logic [5:0] F_IMM = 6'b010000;
    localparam logic [5:0] F_BR = 6'b001000;
    localparam logic [5:0] F_ST = 6'b000100;
    localparam logic [5:0] F_NEG = 6'b000010;
    localparam logic [5:0] F_CI = 6'b000001;
    localparam logic [2:0] U_RD = 3'b100;
    localparam logic [2:0] U_RS2 = 3'b010;
    localparam logic [2:0] U_RS1 = 3'b001;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_req_t  fetch_req;
    logic        decode_valid;
    logic        decode_ready = 1'b0;
    decode_rsp_t decode_rsp;
    sched_note_t sched_note;
    logic        stall_en;
    logic [31:0] lcg_state = 32'ha6f2_a928;
    string       name_q[$];
    instr_t      instr_q[$];
    decode_rsp_t exp_q[$];
    logic        unlock_q[$];

    always #20 clk = ~clk;

    warp_decode DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_req    (fetch_req),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_rsp   (decode_rsp),
        .sched_note   (sched_note)
    );

    decode_checker CHK (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_rsp   (decode_rsp),
        .sched_note   (sched_note)
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function imm_t sext12(input logic [11:0] v);
        return {{8{v[11]}}, v};
    endfunction

    function instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2, input logic [4:0] rs1,
                           input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1, input logic [2:0] f3,
                           input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2, input logic [4:0] rs1,
                           input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `DEC_OP_S};
    endfunction

    // B field kept raw, halfword units
    function instr_t enc_b(input logic [11:0] imm, input logic [4:0] rs2, input logic [4:0] rs1,
                           input logic [2:0] f3);
        return {imm[11], imm[9:4], rs2, rs1, f3, imm[3:0], imm[10], `DEC_OP_B};
    endfunction

    function instr_t enc_j(input logic [19:0] imm, input logic [4:0] rd);
        return {imm[19], imm[9:0], imm[10], imm[18:11], rd, `DEC_OP_JAL};
    endfunction

    task add_case(input string name, input instr_t instr, input ex_type_e ex, input op_type_t op,
                  input imm_t imm, input logic [5:0] fl, input logic [2:0] use_bits,
                  input xregs_t rdx, input xregs_t wrx, input logic unlock);
        decode_rsp_t r;
        r                  = '0;
        r.ex_type          = ex;
        r.op_type          = op;
        r.op_args.imm      = imm;
        r.op_args.use_pc   = fl[5];
        r.op_args.use_imm  = fl[4];
        r.op_args.xtype    = fl[3] ? ALU_BRANCH : ALU_ARITH;
        r.op_args.is_store = fl[2];
        r.op_args.is_neg   = fl[1];
        r.op_args.csr_imm  = fl[0];
        r.used_rs          = {1'b0, use_bits[1], use_bits[0]};
        r.rd               = use_bits[2] ? instr[11:7] : 5'd0;
        r.rs1              = use_bits[0] ? instr[19:15] : 5'd0;
        r.rs2              = use_bits[1] ? instr[24:20] : 5'd0;
        r.wb               = use_bits[2] && (instr[11:7] != 5'd0);
        r.rd_xregs         = rdx;
        r.wr_xregs         = wrx;
        name_q.push_back(name);
        instr_q.push_back(instr);
        exp_q.push_back(r);
        unlock_q.push_back(unlock);
    endtask

    task build_table();
        add_case("add", enc_r(7'h00, 5'd2, 5'd1, 3'h0, 5'd3, `DEC_OP_R), EX_ALU, OP_ALU_ADD,
                 '0, 6'b0, U_RD | U_RS1 | U_RS2, 2'b00, 2'b00, 1'b1);
        add_case("sub", enc_r(7'h20, 5'd7, 5'd6, 3'h0, 5'd5, `DEC_OP_R), EX_ALU, OP_ALU_SUB,
                 '0, 6'b0, U_RD | U_RS1 | U_RS2, 2'b00, 2'b00, 1'b1);
        add_case("srai", enc_i(12'h403, 5'd9, 3'h5, 5'd8, `DEC_OP_I), EX_ALU, OP_ALU_SRA,
                 20'd3, F_IMM, U_RD | U_RS1, 2'b00, 2'b00, 1'b1);
        add_case("sltiu", enc_i(12'hfff, 5'd11, 3'h3, 5'd10, `DEC_OP_I), EX_ALU, OP_ALU_SLTU,
                 sext12(12'hfff), F_IMM, U_RD | U_RS1, 2'b00, 2'b00, 1'b1);
        add_case("addi_x0", enc_i(12'h405, 5'd1, 3'h0, 5'd0, `DEC_OP_I), EX_ALU, OP_ALU_ADD,
                 20'h00405, F_IMM, U_RD | U_RS1, 2'b00, 2'b00, 1'b1);
        add_case("lui", {20'habcde, 5'd12, `DEC_OP_LUI}, EX_ALU, OP_ALU_LUI,
                 20'habcde, F_IMM, U_RD, 2'b00, 2'b00, 1'b1);
        add_case("auipc", {20'h12345, 5'd13, `DEC_OP_AUIPC}, EX_ALU, OP_ALU_AUIPC,
                 20'h12345, F_PC | F_IMM, U_RD, 2'b00, 2'b00, 1'b1);
        add_case("beq", enc_b(12'hf80, 5'd2, 5'd1, 3'h0), EX_ALU, OP_BR_BEQ,
                 sext12(12'hf80), F_PC | F_IMM | F_BR, U_RS1 | U_RS2, 2'b00, 2'b00, 1'b0);
        add_case("bgeu", enc_b(12'h010, 5'd4, 5'd3, 3'h7), EX_ALU, OP_BR_BGEU,
                 20'h00010, F_PC | F_IMM | F_BR, U_RS1 | U_RS2, 2'b00, 2'b00, 1'b0);
        add_case("jal", enc_j(20'h80123, 5'd1), EX_ALU, OP_BR_JAL,
                 20'h80123, F_PC | F_IMM | F_BR, U_RD, 2'b00, 2'b00, 1'b0);
        add_case("jalr", enc_i(12'hff8, 5'd5, 3'h0, 5'd1, `DEC_OP_JALR), EX_ALU, OP_BR_JALR,
                 sext12(12'hff8), F_IMM | F_BR, U_RD | U_RS1, 2'b00, 2'b00, 1'b0);
        add_case("ecall", 32'h0000_0073, EX_ALU, OP_BR_ECALL,
                 20'd4, F_PC | F_IMM | F_BR, U_RD, 2'b00, 2'b00, 1'b0);
        add_case("mret", 32'h3020_0073, EX_ALU, OP_BR_MRET,
                 20'd4, F_PC | F_IMM | F_BR, U_RD, 2'b00, 2'b00, 1'b0);
        add_case("lw", enc_i(12'h00c, 5'd15, 3'h2, 5'd14, `DEC_OP_L), EX_LSU, 4'd2,
                 20'd12, 6'b0, U_RD | U_RS1, 2'b00, 2'b00, 1'b1);
        add_case("sb", enc_s(12'hffc, 5'd16, 5'd17, 3'h0), EX_LSU, 4'd8,
                 sext12(12'hffc), F_ST, U_RS1 | U_RS2, 2'b00, 2'b00, 1'b1);
        add_case("fence", 32'h0ff0_000f, EX_LSU, OP_LSU_FENCE,
                 '0, 6'b0, 3'b000, 2'b00, 2'b00, 1'b1);
        add_case("csrrw_fflags", enc_i(12'h001, 5'd2, 3'h1, 5'd1, `DEC_OP_SYS), EX_SFU,
                 OP_SFU_CSRRW, 20'h001, 6'b0, U_RD | U_RS1, 2'b01, 2'b01, 1'b1);
        add_case("csrrw_frm_x0", enc_i(12'h002, 5'd0, 3'h1, 5'd2, `DEC_OP_SYS), EX_SFU,
                 OP_SFU_CSRRW, 20'h002, 6'b0, U_RD | U_RS1, 2'b10, 2'b10, 1'b1);
        add_case("csrrs_frm_x0", enc_i(12'h002, 5'd0, 3'h2, 5'd3, `DEC_OP_SYS), EX_SFU,
                 OP_SFU_CSRRS, 20'h002, 6'b0, U_RD | U_RS1, 2'b10, 2'b00, 1'b1);
        add_case("csrrs_fcsr", enc_i(12'h003, 5'd5, 3'h2, 5'd4, `DEC_OP_SYS), EX_SFU,
                 OP_SFU_CSRRS, 20'h003, 6'b0, U_RD | U_RS1, 2'b11, 2'b11, 1'b1);
        add_case("csrrsi_fflags_0", enc_i(12'h001, 5'd0, 3'h6, 5'd6, `DEC_OP_SYS), EX_SFU,
                 OP_SFU_CSRRS, 20'h001, F_CI, U_RD, 2'b01, 2'b00, 1'b1);
        add_case("csrrsi_fcsr_5", enc_i(12'h003, 5'd5, 3'h6, 5'd7, `DEC_OP_SYS), EX_SFU,
                 OP_SFU_CSRRS, 20'h003, F_CI, U_RD, 2'b11, 2'b11, 1'b1);
        add_case("tmc", enc_r(7'h00, 5'd0, 5'd3, 3'h0, 5'd0, `DEC_OP_EXT1), EX_SFU, OP_SFU_TMC,
                 '0, 6'b0, U_RS1, 2'b00, 2'b00, 1'b0);
        add_case("wspawn", enc_r(7'h00, 5'd5, 5'd4, 3'h1, 5'd0, `DEC_OP_EXT1), EX_SFU,
                 OP_SFU_WSPAWN, '0, 6'b0, U_RS1 | U_RS2, 2'b00, 2'b00, 1'b0);
        add_case("split_neg", enc_r(7'h00, 5'd1, 5'd7, 3'h2, 5'd6, `DEC_OP_EXT1), EX_SFU,
                 OP_SFU_SPLIT, '0, F_NEG, U_RD | U_RS1, 2'b00, 2'b00, 1'b0);
        add_case("join", enc_r(7'h00, 5'd0, 5'd8, 3'h3, 5'd0, `DEC_OP_EXT1), EX_SFU,
                 OP_SFU_JOIN, '0, 6'b0, U_RS1, 2'b00, 2'b00, 1'b0);
        add_case("barrier", enc_r(7'h00, 5'd10, 5'd9, 3'h4, 5'd0, `DEC_OP_EXT1), EX_SFU,
                 OP_SFU_BARRIER, '0, 6'b0, U_RS1 | U_RS2, 2'b00, 2'b00, 1'b0);
        add_case("pred_neg", enc_r(7'h00, 5'd12, 5'd11, 3'h5, 5'd1, `DEC_OP_EXT1), EX_SFU,
                 OP_SFU_PRED, '0, F_NEG, U_RS1 | U_RS2, 2'b00, 2'b00, 1'b0);
    endtask

    // Random back-pressure, about one stall cycle in four
    always @(negedge clk) begin
        if (stall_en)
            decode_ready = (lcg_next() & 32'h3) != 32'h0;
    end

    initial begin
        int          cnt;
        logic        timed_out;
        logic [31:0] r;
        decode_rsp_t exp_rsp;
        arst_n       = 1'b0;
        fetch_valid  = 1'b0;
        fetch_req    = '0;
        stall_en     = 1'b0;
        timed_out    = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n   = 1'b1;
        stall_en = 1'b1;
        for (int i = 0; i < name_q.size() && !timed_out; i++) begin
            r = lcg_next();
            if (r[3:2] == 2'b00) begin
                fetch_valid = 1'b0;
                repeat (r[4] ? 2 : 1) @(negedge clk); // Idle gap
            end
            exp_rsp       = exp_q[i];
            exp_rsp.wid   = r[9:8];
            exp_rsp.tmask = r[13:10] | 4'b0001;
            exp_rsp.pc    = {r[31:14], 14'h0} | {18'h0, r[13:2], 2'b00};
            CHK.push_expected(name_q[i], exp_rsp, unlock_q[i]);
            fetch_req.wid   = exp_rsp.wid;
            fetch_req.tmask = exp_rsp.tmask;
            fetch_req.pc    = exp_rsp.pc;
            fetch_req.instr = instr_q[i];
            fetch_valid     = 1'b1;
            cnt = 0;
            while (CHK.fetch_count <= i && cnt < TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (CHK.fetch_count <= i) begin
                $display("Timed out waiting for fetch_ready on %s", name_q[i]);
                timed_out = 1'b1;
            end
        end
        fetch_valid = 1'b0;
        cnt = 0;
        while (!timed_out && CHK.check_count < name_q.size() && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!timed_out && CHK.check_count < name_q.size()) begin
            $display("Timed out waiting for the remaining decoded records");
            timed_out = 1'b1;
        end
        CHK.print_counts();
        if (!timed_out && CHK.fail_count == 0 && CHK.check_count == name_q.size()) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
decode_pkg.sv
imm_gen.sv
op_decoder.sv
csr_dep.sv
decode_buffer.sv
warp_decode.sv
decode_checker.sv
tb_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
